//--- hw/id_pkg.sv
////////////////////////////////////////
// Types shared by the RV32I decode stage
// RV32I base opcodes only, FENCE and SYSTEM decode as illegal
// lsu_size_e encoding 2'b11 is never produced
////////////////////////////////////////
package id_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Major opcodes in use
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU operations, compares last
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_XOR  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A  = 2'd0,
    OP_A_FWD    = 2'd1,
    OP_A_CURRPC = 2'd2,
    OP_A_ZERO   = 2'd3
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B = 1'b0,
    OP_B_IMM   = 1'b1
  } op_b_sel_e;

  // Immediate kinds for operand B
  typedef enum logic [2:0] {
    IMM_B_I         = 3'd0,
    IMM_B_S         = 3'd1,
    IMM_B_B         = 3'd2,
    IMM_B_U         = 3'd3,
    IMM_B_J         = 3'd4,
    IMM_B_INCR_PC   = 3'd5,
    IMM_B_INCR_ADDR = 3'd6
  } imm_b_sel_e;

  // Access size, LSU type encoding
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_size_e;

  // Decoder control bundle
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    logic       lsu_req;
    logic       lsu_we;
    lsu_size_e  lsu_size;
    logic       lsu_sign_ext;
    logic       branch;
    logic       jump;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic            req;
    logic            we;
    lsu_size_e       size;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [4:0] raddr_a;
    logic [4:0] raddr_b;
    logic       ren_a;
    logic       ren_b;
  } rf_rd_t;

  typedef struct packed {
    logic            we;
    logic [4:0]      waddr;
    logic [XLEN-1:0] wdata;
  } rf_wr_t;

endpackage

//--- hw/id_decoder.sv
////////////////////////////////////////
// Combinational RV32I decoder
// No FENCE, SYSTEM, M or C encodings, all flagged illegal
// Rv32e makes any used register index of 16 or above illegal
////////////////////////////////////////
`timescale 1ns/1ps

module id_decoder import id_pkg::*; #(
  parameter bit Rv32e = 1'b0
) (
  input  logic [XLEN-1:0] instr_i,
  output dec_ctrl_t       ctrl_o,
  output logic [XLEN-1:0] imm_i_o,
  output logic [XLEN-1:0] imm_s_o,
  output logic [XLEN-1:0] imm_b_o,
  output logic [XLEN-1:0] imm_u_o,
  output logic [XLEN-1:0] imm_j_o,
  output logic [4:0]      raddr_a_o,
  output logic [4:0]      raddr_b_o,
  output logic [4:0]      waddr_o,
  output logic            ren_a_o,
  output logic            ren_b_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  dec_ctrl_t  ctrl_dec;
  logic       illegal_enc;
  logic       illegal_reg;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register indices straight from the fixed fields
  assign raddr_a_o = instr_i[19:15];
  assign raddr_b_o = instr_i[24:20];
  assign waddr_o   = instr_i[11:7];

  ////////////////////////////////////////
  // Immediates, all sign-extended from bit 31
  ////////////////////////////////////////
  assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
  assign imm_u_o = {instr_i[31:12], 12'h000};
  assign imm_j_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////
  always_comb begin : decode
    ctrl_dec           = '0;
    ctrl_dec.alu_op    = ALU_ADD;
    ctrl_dec.op_a_sel  = OP_A_REG_A;
    ctrl_dec.op_b_sel  = OP_B_IMM;
    ctrl_dec.imm_b_sel = IMM_B_I;
    ctrl_dec.lsu_size  = LSU_WORD;
    illegal_enc        = 1'b0;
    ren_a_o            = 1'b0;
    ren_b_o            = 1'b0;

    case (opcode)
      OPCODE_LUI: begin
        // Zero plus upper immediate
        ctrl_dec.op_a_sel  = OP_A_ZERO;
        ctrl_dec.imm_b_sel = IMM_B_U;
        ctrl_dec.rf_we     = 1'b1;
      end
      OPCODE_AUIPC: begin
        ctrl_dec.op_a_sel  = OP_A_CURRPC;
        ctrl_dec.imm_b_sel = IMM_B_U;
        ctrl_dec.rf_we     = 1'b1;
      end
      OPCODE_JAL: begin
        // ALU forms the link address PC + 4
        ctrl_dec.jump      = 1'b1;
        ctrl_dec.op_a_sel  = OP_A_CURRPC;
        ctrl_dec.imm_b_sel = IMM_B_INCR_PC;
        ctrl_dec.rf_we     = 1'b1;
      end
      OPCODE_JALR: begin
        // rs1 read for the target, link as for JAL
        ctrl_dec.jump      = 1'b1;
        ctrl_dec.op_a_sel  = OP_A_CURRPC;
        ctrl_dec.imm_b_sel = IMM_B_INCR_PC;
        ctrl_dec.rf_we     = 1'b1;
        ren_a_o            = 1'b1;
        illegal_enc        = (funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        ctrl_dec.branch    = 1'b1;
        ctrl_dec.op_b_sel  = OP_B_REG_B;
        ctrl_dec.imm_b_sel = IMM_B_B;
        ren_a_o            = 1'b1;
        ren_b_o            = 1'b1;
        case (funct3)
          3'b000:  ctrl_dec.alu_op = ALU_EQ;
          3'b001:  ctrl_dec.alu_op = ALU_NE;
          3'b100:  ctrl_dec.alu_op = ALU_LT;
          3'b101:  ctrl_dec.alu_op = ALU_GE;
          3'b110:  ctrl_dec.alu_op = ALU_LTU;
          3'b111:  ctrl_dec.alu_op = ALU_GEU;
          default: illegal_enc     = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        // Address is rs1 + I immediate
        ctrl_dec.lsu_req      = 1'b1;
        ctrl_dec.rf_we        = 1'b1;
        ctrl_dec.lsu_sign_ext = ~funct3[2];
        ren_a_o               = 1'b1;
        case (funct3[1:0])
          2'b00:   ctrl_dec.lsu_size = LSU_BYTE;
          2'b01:   ctrl_dec.lsu_size = LSU_HALF;
          2'b10:   ctrl_dec.lsu_size = LSU_WORD;
          default: illegal_enc       = 1'b1;
        endcase
        // LWU belongs to RV64
        if (funct3[2] && funct3[1]) begin
          illegal_enc = 1'b1;
        end
      end
      OPCODE_STORE: begin
        ctrl_dec.lsu_req   = 1'b1;
        ctrl_dec.lsu_we    = 1'b1;
        ctrl_dec.imm_b_sel = IMM_B_S;
        ren_a_o            = 1'b1;
        ren_b_o            = 1'b1;
        case (funct3[1:0])
          2'b00:   ctrl_dec.lsu_size = LSU_BYTE;
          2'b01:   ctrl_dec.lsu_size = LSU_HALF;
          2'b10:   ctrl_dec.lsu_size = LSU_WORD;
          default: illegal_enc       = 1'b1;
        endcase
        if (funct3[2]) begin
          illegal_enc = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        ctrl_dec.rf_we = 1'b1;
        ren_a_o        = 1'b1;
        case (funct3)
          3'b000: ctrl_dec.alu_op = ALU_ADD;
          3'b010: ctrl_dec.alu_op = ALU_SLT;
          3'b011: ctrl_dec.alu_op = ALU_SLTU;
          3'b100: ctrl_dec.alu_op = ALU_XOR;
          3'b110: ctrl_dec.alu_op = ALU_OR;
          3'b001: begin
            ctrl_dec.alu_op = ALU_SLL;
            illegal_enc     = (funct7 != 7'h00);
          end
          3'b101: begin
            // funct7 bit 5 picks arithmetic shift
            ctrl_dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_enc     = ({funct7[6], funct7[4:0]} != 6'b0);
          end
          default: ctrl_dec.alu_op = ALU_AND;
        endcase
      end
      OPCODE_OP: begin
        ctrl_dec.op_b_sel = OP_B_REG_B;
        ctrl_dec.rf_we    = 1'b1;
        ren_a_o           = 1'b1;
        ren_b_o           = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_dec.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl_dec.alu_op = ALU_SUB;
          {7'h00, 3'b001}: ctrl_dec.alu_op = ALU_SLL;
          {7'h00, 3'b010}: ctrl_dec.alu_op = ALU_SLT;
          {7'h00, 3'b011}: ctrl_dec.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: ctrl_dec.alu_op = ALU_XOR;
          {7'h00, 3'b101}: ctrl_dec.alu_op = ALU_SRL;
          {7'h20, 3'b101}: ctrl_dec.alu_op = ALU_SRA;
          {7'h00, 3'b110}: ctrl_dec.alu_op = ALU_OR;
          {7'h00, 3'b111}: ctrl_dec.alu_op = ALU_AND;
          default:         illegal_enc     = 1'b1;
        endcase
      end
      default: illegal_enc = 1'b1;
    endcase
  end

  // RV32E only has x0 to x15
  assign illegal_reg = Rv32e & ((ren_a_o & instr_i[19]) | (ren_b_o & instr_i[24]) |
                                (ctrl_dec.rf_we & instr_i[11]));
  assign illegal     = illegal_enc | illegal_reg;

  // Illegal instruction keeps no side effects
  always_comb begin : illegal_clear
    ctrl_o         = ctrl_dec;
    ctrl_o.illegal = illegal;
    if (illegal) begin
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.lsu_req = 1'b0;
      ctrl_o.lsu_we  = 1'b0;
      ctrl_o.branch  = 1'b0;
      ctrl_o.jump    = 1'b0;
    end
  end

endmodule

//--- hw/id_operand_mux.sv
////////////////////////////////////////
// ALU operand selection
// Misaligned second address overrides the decoder selectors
////////////////////////////////////////
`timescale 1ns/1ps

module id_operand_mux import id_pkg::*; (
  input  dec_ctrl_t       ctrl_i,
  input  logic [XLEN-1:0] imm_i_i,
  input  logic [XLEN-1:0] imm_s_i,
  input  logic [XLEN-1:0] imm_b_i,
  input  logic [XLEN-1:0] imm_u_i,
  input  logic [XLEN-1:0] imm_j_i,
  input  logic [XLEN-1:0] rdata_a_i,
  input  logic [XLEN-1:0] rdata_b_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  input  logic            lsu_addr_incr_req_i,
  input  logic            instr_valid_i,
  output alu_req_t        alu_req_o
);

  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;
  logic [XLEN-1:0] imm;

  // Second access of a split load/store is last address + 4
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : ctrl_i.op_a_sel;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : ctrl_i.op_b_sel;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : ctrl_i.imm_b_sel;

  always_comb begin : imm_mux
    case (imm_b_sel)
      IMM_B_I: imm = imm_i_i;
      IMM_B_S: imm = imm_s_i;
      IMM_B_B: imm = imm_b_i;
      IMM_B_U: imm = imm_u_i;
      IMM_B_J: imm = imm_j_i;
      // No compressed, PC always steps by 4
      default: imm = 32'h4;
    endcase
  end

  always_comb begin : op_a_mux
    case (op_a_sel)
      OP_A_REG_A:  alu_req_o.operand_a = rdata_a_i;
      OP_A_FWD:    alu_req_o.operand_a = lsu_addr_last_i;
      OP_A_CURRPC: alu_req_o.operand_a = pc_i;
      default:     alu_req_o.operand_a = '0;
    endcase
  end

  assign alu_req_o.operand_b = (op_b_sel == OP_B_IMM) ? imm : rdata_b_i;
  assign alu_req_o.op        = ctrl_i.alu_op;

  // Decoder and override only ever pick a defined kind
  always_comb begin : imm_sel_check
    if (instr_valid_i) begin
      assert (imm_b_sel inside {IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J,
                                IMM_B_INCR_PC, IMM_B_INCR_ADDR})
        else $error("immediate selector out of range: %0d", imm_b_sel);
    end
  end

endmodule

//--- hw/id_fsm.sv
////////////////////////////////////////
// First/multi-cycle FSM of the decode stage
// No writeback stage, so loads finish on lsu_resp_valid_i
// branch_decision_i is sampled in the first cycle only
////////////////////////////////////////
`timescale 1ns/1ps

module id_fsm import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  dec_ctrl_t ctrl_i,
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,
  input  logic      lsu_resp_valid_i,
  output logic      first_cycle_o,
  output logic      instr_executing_o,
  output logic      rf_we_ok_o,
  output logic      pc_set_o,
  output logic      instr_done_o
);

  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

  id_fsm_e fsm_q;
  id_fsm_e fsm_d;
  logic    multicycle_done;
  logic    stall_mem;
  logic    stall_branch;
  logic    stall_jump;
  logic    stall;
  logic    rf_we_ok;
  logic    branch_set_d;
  logic    branch_set_q;
  logic    jump_set;
  logic    set_done_d;
  logic    set_done_q;

  // Every valid instruction executes
  assign instr_executing_o = instr_valid_i;
  assign first_cycle_o     = instr_valid_i & (fsm_q == FIRST_CYCLE);

  // Memory ops wait on the LSU, the rest on EX
  assign multicycle_done = ctrl_i.lsu_req ? lsu_resp_valid_i : ex_valid_i;

  ////////////////////////////////////////
  // Next state and stalls
  ////////////////////////////////////////
  always_comb begin : fsm_comb
    fsm_d        = fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;
    rf_we_ok     = 1'b1;

    if (instr_executing_o) begin
      case (fsm_q)
        FIRST_CYCLE: begin
          if (ctrl_i.lsu_req) begin
            // Load data never arrives in the request cycle
            fsm_d    = MULTI_CYCLE;
            rf_we_ok = 1'b0;
          end else if (ctrl_i.branch) begin
            // Taken branch sets the PC next cycle
            fsm_d        = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.jump) begin
            fsm_d      = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
            rf_we_ok   = 1'b0;
          end
        end
        default: begin
          rf_we_ok = multicycle_done;
          if (multicycle_done) begin
            fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = ctrl_i.branch;
            stall_jump   = ctrl_i.jump;
          end
        end
      endcase
    end
  end

  // Request cycle always stalls, then until the response
  assign stall_mem = instr_valid_i & ctrl_i.lsu_req & (~lsu_resp_valid_i | first_cycle_o);
  assign stall     = stall_mem | stall_branch | stall_jump;

  assign instr_done_o = instr_executing_o & ~stall;
  assign rf_we_ok_o   = instr_executing_o & rf_we_ok;

  // One set per instruction, flag cleared when it leaves
  assign pc_set_o   = (branch_set_q | jump_set) & ~set_done_q;
  assign set_done_d = (branch_set_q | jump_set | set_done_q) & ~instr_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q        <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      fsm_q        <= fsm_d;
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////
  // Decoder gives at most one execution class
  a_class_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> $onehot0({ctrl_i.lsu_req, ctrl_i.branch, ctrl_i.jump, ctrl_i.illegal}));

  a_multi_stalls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fsm_q == FIRST_CYCLE) && (fsm_d == MULTI_CYCLE) |-> stall);

endmodule

//--- hw/id_stage.sv
////////////////////////////////////////
// RV32I decode stage without writeback
// Instruction must stay stable until instr_done_o
// Write data always comes from the EX result
////////////////////////////////////////
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
  parameter bit Rv32e = 1'b0
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic [XLEN-1:0] pc_id_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  logic [XLEN-1:0] result_ex_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  input  logic            lsu_addr_incr_req_i,
  input  logic            branch_decision_i,
  input  logic            ex_valid_i,
  input  logic            lsu_resp_valid_i,
  output alu_req_t        alu_req_o,
  output lsu_req_t        lsu_req_o,
  output rf_rd_t          rf_rd_o,
  output rf_wr_t          rf_wr_o,
  output logic            illegal_insn_o,
  output logic            pc_set_o,
  output logic            instr_done_o,
  output logic            id_in_ready_o
);

  dec_ctrl_t       ctrl;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [4:0]      waddr;
  logic            ren_a_dec;
  logic            ren_b_dec;
  logic            first_cycle;
  logic            instr_executing;
  logic            rf_we_ok;

  id_decoder #(
    .Rv32e(Rv32e)
  ) decoder_i (
    .instr_i  (instr_rdata_i),
    .ctrl_o   (ctrl),
    .imm_i_o  (imm_i),
    .imm_s_o  (imm_s),
    .imm_b_o  (imm_b),
    .imm_u_o  (imm_u),
    .imm_j_o  (imm_j),
    .raddr_a_o(rf_rd_o.raddr_a),
    .raddr_b_o(rf_rd_o.raddr_b),
    .waddr_o  (waddr),
    .ren_a_o  (ren_a_dec),
    .ren_b_o  (ren_b_dec)
  );

  id_operand_mux operand_mux_i (
    .ctrl_i             (ctrl),
    .imm_i_i            (imm_i),
    .imm_s_i            (imm_s),
    .imm_b_i            (imm_b),
    .imm_u_i            (imm_u),
    .imm_j_i            (imm_j),
    .rdata_a_i          (rf_rdata_a_i),
    .rdata_b_i          (rf_rdata_b_i),
    .pc_i               (pc_id_i),
    .lsu_addr_last_i    (lsu_addr_last_i),
    .lsu_addr_incr_req_i(lsu_addr_incr_req_i),
    .instr_valid_i      (instr_valid_i),
    .alu_req_o          (alu_req_o)
  );

  id_fsm fsm_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .ctrl_i           (ctrl),
    .branch_decision_i(branch_decision_i),
    .ex_valid_i       (ex_valid_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .first_cycle_o    (first_cycle),
    .instr_executing_o(instr_executing),
    .rf_we_ok_o       (rf_we_ok),
    .pc_set_o         (pc_set_o),
    .instr_done_o     (instr_done_o)
  );

  assign illegal_insn_o = instr_valid_i & ctrl.illegal;

  // Reads only for valid legal instructions
  assign rf_rd_o.ren_a = instr_valid_i & ~illegal_insn_o & ren_a_dec;
  assign rf_rd_o.ren_b = instr_valid_i & ~illegal_insn_o & ren_b_dec;

  // Request only once, in the first cycle
  assign lsu_req_o.req      = instr_executing & first_cycle & ctrl.lsu_req;
  assign lsu_req_o.we       = ctrl.lsu_we;
  assign lsu_req_o.size     = ctrl.lsu_size;
  assign lsu_req_o.sign_ext = ctrl.lsu_sign_ext;
  assign lsu_req_o.wdata    = rf_rdata_b_i;

  assign rf_wr_o.we    = ctrl.rf_we & rf_we_ok;
  assign rf_wr_o.waddr = waddr;
  assign rf_wr_o.wdata = result_ex_i;

  // Fetch may hand over the next instruction
  assign id_in_ready_o = ~instr_valid_i | instr_done_o;

endmodule

//--- verification/tb_id_stage.sv
////////////////////////////////////////
// Trace-driven testbench of the decode stage
// Run from the project root, trace in verification/
// RV32E register limit on, ex_valid_i held high
////////////////////////////////////////
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int    CLK_PERIOD   = 40;
  localparam int    DRIVE_DELAY  = 2;
  localparam int    SAMPLE_DELAY = 18;
  localparam int    MAX_CYCLES   = 16;
  localparam string TRACE_FILE   = "verification/id_trace.txt";

  logic            clk;
  logic            rst_n;
  logic            instr_valid;
  logic [XLEN-1:0] instr_rdata;
  logic [XLEN-1:0] pc_id;
  logic [XLEN-1:0] rf_rdata_a;
  logic [XLEN-1:0] rf_rdata_b;
  logic [XLEN-1:0] result_ex;
  logic [XLEN-1:0] lsu_addr_last;
  logic            lsu_addr_incr_req;
  logic            branch_decision;
  logic            ex_valid;
  logic            lsu_resp_valid;
  alu_req_t        alu_req;
  lsu_req_t        lsu_req;
  rf_rd_t          rf_rd;
  rf_wr_t          rf_wr;
  logic            illegal_insn;
  logic            pc_set;
  logic            instr_done;
  logic            id_in_ready;

  // Fields of the current trace line
  logic [31:0] t_instr;
  logic [31:0] t_pc;
  logic [31:0] t_rdata_a;
  logic [31:0] t_rdata_b;
  logic [31:0] t_branch;
  logic [31:0] t_delay;
  logic [31:0] t_incr;
  logic [31:0] t_addr_last;
  logic [31:0] t_alu_op;
  logic [31:0] t_op_a;
  logic [31:0] t_op_b;
  logic [31:0] t_lsu_req;
  logic [31:0] t_lsu_we;
  logic [31:0] t_size;
  logic [31:0] t_sign_ext;
  logic [31:0] t_rf_we;
  logic [31:0] t_waddr;
  logic [31:0] t_illegal;
  logic [31:0] t_pc_set;
  logic [31:0] t_cycles;

  int unsigned line_no;
  int unsigned executed;
  int unsigned error_count;

  id_stage #(
    .Rv32e(1'b1)
  ) id_stage_i (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .instr_valid_i      (instr_valid),
    .instr_rdata_i      (instr_rdata),
    .pc_id_i            (pc_id),
    .rf_rdata_a_i       (rf_rdata_a),
    .rf_rdata_b_i       (rf_rdata_b),
    .result_ex_i        (result_ex),
    .lsu_addr_last_i    (lsu_addr_last),
    .lsu_addr_incr_req_i(lsu_addr_incr_req),
    .branch_decision_i  (branch_decision),
    .ex_valid_i         (ex_valid),
    .lsu_resp_valid_i   (lsu_resp_valid),
    .alu_req_o          (alu_req),
    .lsu_req_o          (lsu_req),
    .rf_rd_o            (rf_rd),
    .rf_wr_o            (rf_wr),
    .illegal_insn_o     (illegal_insn),
    .pc_set_o           (pc_set),
    .instr_done_o       (instr_done),
    .id_in_ready_o      (id_in_ready)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("error: trace line %0d %s is %h, expected %h", line_no, name, actual, expected);
      $display("Something failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // Source registers read per RV32I major opcode
  // Bit 0 for rs1, bit 1 for rs2
  function automatic logic [1:0] source_regs(input logic [31:0] instr);
    case (instr[6:0])
      // OP, STORE and BRANCH read both
      7'h33, 7'h23, 7'h63: source_regs = 2'b11;
      // OP-IMM, LOAD and JALR read rs1 only
      7'h13, 7'h03, 7'h67: source_regs = 2'b01;
      default:             source_regs = 2'b00;
    endcase
  endfunction

  // Per-cycle checks, sampled mid-cycle
  task automatic check_cycle(input int unsigned cycle);
    logic       last;
    logic [1:0] reads;
    last = (cycle == t_cycles);
    check_value("instr_done_o", 32'(instr_done), 32'(last));
    check_value("id_in_ready_o", 32'(id_in_ready), 32'(last));
    check_value("illegal_insn_o", 32'(illegal_insn), t_illegal);
    // Request only in the first cycle
    check_value("lsu_req_o.req", 32'(lsu_req.req), (cycle == 1) ? t_lsu_req : 32'h0);
    // Write only as the instruction completes
    check_value("rf_wr_o.we", 32'(rf_wr.we), last ? t_rf_we : 32'h0);
    if (last && t_rf_we != 0) begin
      check_value("rf_wr_o.waddr", 32'(rf_wr.waddr), t_waddr);
      check_value("rf_wr_o.wdata", rf_wr.wdata, result_ex);
    end
    if (cycle == 1) begin
      if (t_illegal != 0) begin
        check_value("rf_rd_o.ren_a", 32'(rf_rd.ren_a), 32'h0);
        check_value("rf_rd_o.ren_b", 32'(rf_rd.ren_b), 32'h0);
      end else begin
        reads = source_regs(t_instr);
        check_value("alu_req_o.op", 32'(alu_req.op), t_alu_op);
        check_value("alu_req_o.operand_a", alu_req.operand_a, t_op_a);
        check_value("alu_req_o.operand_b", alu_req.operand_b, t_op_b);
        check_value("rf_rd_o.ren_a", 32'(rf_rd.ren_a), 32'(reads[0]));
        check_value("rf_rd_o.ren_b", 32'(rf_rd.ren_b), 32'(reads[1]));
        // rs1 and rs2 sit at fixed instruction bits
        if (reads[0]) begin
          check_value("rf_rd_o.raddr_a", 32'(rf_rd.raddr_a), 32'(t_instr[19:15]));
        end
        if (reads[1]) begin
          check_value("rf_rd_o.raddr_b", 32'(rf_rd.raddr_b), 32'(t_instr[24:20]));
        end
      end
      if (t_lsu_req != 0) begin
        check_value("lsu_req_o.we", 32'(lsu_req.we), t_lsu_we);
        check_value("lsu_req_o.size", 32'(lsu_req.size), t_size);
        check_value("lsu_req_o.sign_ext", 32'(lsu_req.sign_ext), t_sign_ext);
        // Store data straight from register B
        if (t_lsu_we != 0) begin
          check_value("lsu_req_o.wdata", lsu_req.wdata, t_rdata_b);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Driver
  ////////////////////////////////////////
  // One empty cycle between instructions
  task automatic idle_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    instr_valid       = 1'b0;
    lsu_resp_valid    = 1'b0;
    lsu_addr_incr_req = 1'b0;
    branch_decision   = 1'b0;
    #SAMPLE_DELAY;
    check_value("idle id_in_ready_o", 32'(id_in_ready), 32'h1);
    check_value("idle pc_set_o", 32'(pc_set), 32'h0);
    check_value("idle lsu_req_o.req", 32'(lsu_req.req), 32'h0);
    check_value("idle rf_wr_o.we", 32'(rf_wr.we), 32'h0);
    check_value("idle illegal_insn_o", 32'(illegal_insn), 32'h0);
  endtask

  // Hold the instruction until done, bounded by MAX_CYCLES
  task automatic execute_instruction();
    int unsigned cycle;
    logic [31:0] pc_set_seen;
    logic        done;
    cycle       = 1;
    pc_set_seen = '0;
    done        = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    instr_valid       = 1'b1;
    instr_rdata       = t_instr;
    pc_id             = t_pc;
    rf_rdata_a        = t_rdata_a;
    rf_rdata_b        = t_rdata_b;
    branch_decision   = t_branch[0];
    lsu_addr_incr_req = t_incr[0];
    lsu_addr_last     = t_addr_last;
    result_ex         = t_pc ^ 32'h5a5a_0000;
    lsu_resp_valid    = 1'b0;
    while (!done) begin
      #SAMPLE_DELAY;
      check_cycle(cycle);
      if (pc_set) begin
        pc_set_seen[cycle-1] = 1'b1;
      end
      if (instr_done) begin
        done = 1'b1;
      end else if (cycle >= MAX_CYCLES) begin
        $display("timeout: instruction on trace line %0d never completed", line_no);
        $display("Something failed");
        $fatal(1, "instruction timeout");
      end else begin
        cycle++;
        @(posedge clk);
        #DRIVE_DELAY;
        // Response arrives resp_delay cycles after the request
        lsu_resp_valid = (t_delay != 0) && (cycle > t_delay);
      end
    end
    check_value("pc_set_o cycle mask", pc_set_seen, t_pc_set);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : stimulus
    int    fd;
    int    n;
    string line;
    clk_init_inputs: begin
      rst_n             = 1'b0;
      instr_valid       = 1'b0;
      instr_rdata       = '0;
      pc_id             = '0;
      rf_rdata_a        = '0;
      rf_rdata_b        = '0;
      result_ex         = '0;
      lsu_addr_last     = '0;
      lsu_addr_incr_req = 1'b0;
      branch_decision   = 1'b0;
      ex_valid          = 1'b1;
      lsu_resp_valid    = 1'b0;
    end
    line_no     = 0;
    executed    = 0;
    error_count = 0;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the trace file %s", TRACE_FILE);
      $display("Something failed");
      $fatal(1, "missing trace");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      // Skip blank and comment lines
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    t_instr, t_pc, t_rdata_a, t_rdata_b, t_branch, t_delay, t_incr,
                    t_addr_last, t_alu_op, t_op_a, t_op_b, t_lsu_req, t_lsu_we, t_size,
                    t_sign_ext, t_rf_we, t_waddr, t_illegal, t_pc_set, t_cycles);
        if (n != 20) begin
          $display("trace line %0d has %0d fields instead of 20", line_no, n);
          $display("Something failed");
          $fatal(1, "malformed trace");
        end
        idle_cycle();
        execute_instruction();
        executed++;
      end
    end
    $fclose(fd);

    if (error_count == 0 && executed != 0) begin
      $display("Everything OK");
    end else begin
      if (executed == 0) begin
        $display("the trace held no instructions");
      end
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- id_stage.f
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_operand_mux.sv
hw/id_fsm.sv
hw/id_stage.sv
verification/tb_id_stage.sv

//--- Makefile
# Verilator flow for the RV32I decode stage
TOP := tb_id_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f id_stage.f --top-module id_stage

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f id_stage.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- verification/id_trace.txt
# in:  instr pc rdata_a rdata_b br_taken resp_delay incr_req addr_last
# exp: alu_op op_a op_b lsu_req lsu_we size sign_ext rf_we waddr illegal pc_set_mask cycles
# pc_set_mask bit 0 is the first cycle, size is 0 word 1 half 2 byte
ffb10093 00000100 00000020 00000000 0 0 0 00000000 00 00000020 fffffffb 0 0 0 0 1 01 0 0 1
005201b3 00000104 00001111 00002222 0 0 0 00000000 00 00001111 00002222 0 0 0 0 1 03 0 0 1
40838333 00000108 80000000 00000001 0 0 0 00000000 01 80000000 00000001 0 0 0 0 1 06 0 0 1
40355493 0000010c f0000000 00000000 0 0 0 00000000 07 f0000000 00000403 0 0 0 0 1 09 0 0 1
7ff63593 00000110 12345678 00000000 0 0 0 00000000 09 12345678 000007ff 0 0 0 0 1 0b 0 0 1
abcde6b7 00000114 deadbeef 00000000 0 0 0 00000000 00 00000000 abcde000 0 0 0 0 1 0d 0 0 1
12345717 00000118 deadbeef 00000000 0 0 0 00000000 00 00000118 12345000 0 0 0 0 1 0e 0 0 1
009443b3 0000011c 0f0f0f0f f0f0f0f0 0 0 0 00000000 02 0f0f0f0f f0f0f0f0 0 0 0 0 1 07 0 0 1
0080a783 00000120 00002000 00000000 0 2 0 00000000 00 00002000 00000008 1 0 0 1 1 0f 0 0 3
fff1c103 00000124 00003000 00000000 0 1 0 00000000 00 00003000 ffffffff 1 0 2 0 1 02 0 0 2
00229203 00000128 00004000 00000000 0 3 0 00000000 00 00004000 00000002 1 0 1 1 1 04 0 0 4
0063a623 0000012c 00005000 cafef00d 0 1 0 00000000 00 00005000 0000000c 1 1 0 0 0 0c 0 0 2
fe848e23 00000130 00006000 000000a5 0 2 0 00000000 00 00006000 fffffffc 1 1 2 0 0 1c 0 0 3
0080a783 00000134 00002000 00000000 0 1 1 00001003 00 00001003 00000004 1 0 0 1 1 0f 0 0 2
00208863 00000138 00000055 00000055 1 0 0 00000000 0a 00000055 00000055 0 0 0 0 0 10 0 2 2
fe419ce3 0000013c 00000007 00000007 0 0 0 00000000 0b 00000007 00000007 0 0 0 0 0 19 0 0 1
0062f463 00000140 00000009 00000003 1 0 0 00000000 0f 00000009 00000003 0 0 0 0 0 08 0 2 2
100000ef 00000144 00000000 00000000 0 0 0 00000000 00 00000144 00000004 0 0 0 0 1 01 0 1 2
004302e7 00000148 00008000 00000000 0 0 0 00000000 00 00000148 00000004 0 0 0 0 1 05 0 1 2
0000007f 0000014c 00000000 00000000 0 0 0 00000000 00 00000000 00000000 0 0 0 0 0 00 1 0 1
00208833 00000150 00000000 00000000 0 0 0 00000000 00 00000000 00000000 0 0 0 0 0 10 1 0 1
00188093 00000154 00000000 00000000 0 0 0 00000000 00 00000000 00000000 0 0 0 0 0 01 1 0 1
0140a023 00000158 00000000 00000000 0 0 0 00000000 00 00000000 00000000 0 0 0 0 0 00 1 0 1
02000033 0000015c 00000000 00000000 0 0 0 00000000 00 00000000 00000000 0 0 0 0 0 00 1 0 1
